// ==== Bender.yml ====
package:
  name: spi_hex_display

sources:
  - files:
      - src/cmd_pkg.sv
      - src/disp_pkg.sv
      - src/disp_wr_if.sv
      - src/spi_cmd_rx.sv
      - src/cmd_fsm.sv
      - src/debounce_timer.sv
      - src/digit_regs.sv
      - src/spi_hex_display.sv

  - target: test
    files:
      - tests/tb_spi_hex_display.sv

// ==== build.f ====
src/cmd_pkg.sv
src/disp_pkg.sv
src/disp_wr_if.sv
src/spi_cmd_rx.sv
src/cmd_fsm.sv
src/debounce_timer.sv
src/digit_regs.sv
src/spi_hex_display.sv
tests/tb_spi_hex_display.sv

// ==== src/cmd_fsm.sv ====
// command decoder turning received bytes and the clear key into display writes
`timescale 1ns/1ps

module cmd_fsm
        import cmd_pkg::*;
        import disp_pkg::*;
(
        input  logic       clock_50,    // system clock
        input  logic       arst_n,      // async reset, active low
        input  cmd_byte_t  rx_byte,     // byte from the SPI port
        input  logic       rx_valid,    // rx_byte is new
        input  logic       frame_start, // csel just fell
        input  logic       key_press,   // debounced clear key
        disp_wr_if.decoder wr           // to the digit registers
);

        typedef enum logic {
                st_idle,                // expecting an opcode byte
                st_wait_data            // expecting the data byte
        } state_e;

        state_e     state;
        cmd_op_e    op;                 // opcode field of rx_byte
        disp_kind_e kind_q;             // kind held for the data byte
        digit_idx_t idx_q;              // index held for the data byte

        assign op = cmd_op_e'(rx_byte[CMD_OP_LSB +: CMD_OP_W]);

        // ====================
        // control
        // ====================
        always_ff @(posedge clock_50 or negedge arst_n) begin
                if (!arst_n) begin
                        state      <= st_idle;
                        wr.wr_en   <= 1'b0;
                        wr.clr_all <= 1'b0;
                end else begin
                        wr.wr_en   <= 1'b0;
                        wr.clr_all <= key_press;        // local key, any state
                        if (frame_start) begin
                                state <= st_idle;       // resync on every frame
                        end else if (rx_valid) begin
                                case (state)
                                        st_idle: begin
                                                case (op)
                                                        op_write_hex,
                                                        op_write_raw: state <= st_wait_data;
                                                        op_clear:     wr.clr_all <= 1'b1;
                                                        default:      state <= st_idle;
                                                endcase
                                        end
                                        st_wait_data: begin
                                                state    <= st_idle;
                                                wr.wr_en <= (idx_q < NUM_DIGITS); // 6,7 dropped
                                        end
                                        default: state <= st_idle;
                                endcase
                        end
                end
        end

        // ====================
        // write payload
        // ====================
        always_ff @(posedge clock_50) begin
                if (rx_valid && state == st_idle) begin
                        kind_q <= (op == op_write_raw) ? kind_raw : kind_hex;
                        idx_q  <= rx_byte[CMD_IDX_W-1:0];
                end
                if (rx_valid && state == st_wait_data) begin
                        wr.wr_kind <= kind_q;
                        wr.wr_idx  <= idx_q;
                        wr.wr_data <= rx_byte;
                end
        end

endmodule : cmd_fsm

// ==== src/cmd_pkg.sv ====
// command byte layout shared by the SPI receiver and the command decoder, imported by wildcard
package cmd_pkg;

        // ====================
        // byte and field layout
        // ====================
        localparam int CMD_BYTE_W = 8;          // one SPI frame byte
        localparam int CMD_OP_LSB = 5;          // opcode sits in bits 7..5
        localparam int CMD_OP_W   = 3;
        localparam int CMD_IDX_W  = 3;          // digit index in bits 2..0

        typedef logic [CMD_BYTE_W-1:0] cmd_byte_t;

        // ====================
        // opcodes
        // ====================
        // codes 4..7 are reserved and decode as a nop
        typedef enum logic [CMD_OP_W-1:0] {
                op_nop       = 3'd0,            // ignored
                op_write_hex = 3'd1,            // next byte is a hex nibble
                op_write_raw = 3'd2,            // next byte is a segment pattern
                op_clear     = 3'd3             // blank every digit
        } cmd_op_e;

        // frame format, msb first on the wire:
        //   byte 0  op[2:0] | xx | idx[2:0]
        //   byte 1  data, only after op_write_hex or op_write_raw
        //
        // op_clear and op_nop are single-byte commands
        //
        // the decoder restarts at byte 0 on every csel fall, so a write
        // and its data byte must share one frame

endpackage : cmd_pkg

// ==== src/debounce_timer.sv ====
// debouncer for the active-low clear key, one pulse per accepted press
`timescale 1ns/1ps

module debounce_timer #(
        parameter int DEBOUNCE_CYCLES = 50000   // stable cycles before accepting
) (
        input  logic clock_50,                  // system clock
        input  logic arst_n,                    // async reset, active low
        input  logic key_n,                     // raw key, low = pressed
        output logic key_press                  // one cycle per press
);

        localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
        localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEBOUNCE_CYCLES - 1);

        logic [1:0]       key_q;                // synchronizer
        logic             key_last;             // level being timed
        logic             key_level;            // debounced, 1 = released
        logic [CNT_W-1:0] cnt;                  // stable cycles so far

        always_ff @(posedge clock_50 or negedge arst_n) begin
                if (!arst_n) begin
                        key_q     <= 2'b11;             // released
                        key_last  <= 1'b1;
                        key_level <= 1'b1;
                        cnt       <= '0;
                        key_press <= 1'b0;
                end else begin
                        key_q     <= {key_q[0], key_n};
                        key_press <= 1'b0;
                        if (key_q[1] != key_last) begin
                                key_last <= key_q[1];   // bounce, start over
                                cnt      <= '0;
                        end else if (cnt != CNT_MAX) begin
                                cnt <= cnt + 1'b1;
                        end else begin
                                // stable long enough, accept the level
                                key_level <= key_last;
                                if (key_level && !key_last) begin
                                        key_press <= 1'b1;      // released -> pressed
                                end
                        end
                end
        end

endmodule : debounce_timer

// ==== src/digit_regs.sv ====
// six seven-segment digit registers with hex glyph decoding and active-low outputs
`timescale 1ns/1ps

module digit_regs
        import disp_pkg::*;
(
        input  logic    clock_50,       // system clock
        input  logic    arst_n,         // async reset, active low
        disp_wr_if.regs wr,             // writes from the decoder
        output seg_t    hex0,           // active low
        output seg_t    hex1,
        output seg_t    hex2,
        output seg_t    hex3,
        output seg_t    hex4,
        output seg_t    hex5
);

        seg_t digits [NUM_DIGITS];      // lit segments, 1 = on

        // standard 0..F glyphs, bit 0 = a
        function automatic seg_t hex_glyph(input logic [3:0] nib);
                case (nib)
                        4'h0:    return 7'h3F;
                        4'h1:    return 7'h06;
                        4'h2:    return 7'h5B;
                        4'h3:    return 7'h4F;
                        4'h4:    return 7'h66;
                        4'h5:    return 7'h6D;
                        4'h6:    return 7'h7D;
                        4'h7:    return 7'h07;
                        4'h8:    return 7'h7F;
                        4'h9:    return 7'h6F;
                        4'hA:    return 7'h77;
                        4'hB:    return 7'h7C;  // lower case b
                        4'hC:    return 7'h39;
                        4'hD:    return 7'h5E;  // lower case d
                        4'hE:    return 7'h79;
                        default: return 7'h71;  // F
                endcase
        endfunction

        always_ff @(posedge clock_50 or negedge arst_n) begin
                if (!arst_n) begin
                        for (int i = 0; i < NUM_DIGITS; i++) begin
                                digits[i] <= SEG_BLANK;
                        end
                end else begin
                        for (int i = 0; i < NUM_DIGITS; i++) begin
                                if (wr.clr_all) begin
                                        digits[i] <= SEG_BLANK;         // clear wins
                                end else if (wr.wr_en && wr.wr_idx == digit_idx_t'(i)) begin
                                        digits[i] <= (wr.wr_kind == kind_hex)
                                                ? hex_glyph(wr.wr_data[3:0])
                                                : wr.wr_data[6:0];      // raw pattern
                                end
                        end
                end
        end

        // board pins light a segment on 0
        assign hex0 = ~digits[0];
        assign hex1 = ~digits[1];
        assign hex2 = ~digits[2];
        assign hex3 = ~digits[3];
        assign hex4 = ~digits[4];
        assign hex5 = ~digits[5];

endmodule : digit_regs

// ==== src/disp_pkg.sv ====
// seven-segment display types shared by the decoder, digit registers and top level
package disp_pkg;

        // ====================
        // digit bank
        // ====================
        localparam int NUM_DIGITS = 6;          // hex0..hex5
        localparam int DIGIT_IDX_W = 3;         // covers 0..7, 6 and 7 unused
        localparam int SEG_W = 7;               // segments a..g

        typedef logic [DIGIT_IDX_W-1:0] digit_idx_t;

        // bit 0 = segment a ... bit 6 = segment g, 1 = lit
        typedef logic [SEG_W-1:0] seg_t;

        localparam seg_t SEG_BLANK = '0;        // all segments off

        // ====================
        // write kinds
        // ====================
        typedef enum logic {
                kind_hex = 1'b0,                // low nibble through glyph table
                kind_raw = 1'b1                 // low 7 bits stored as is
        } disp_kind_e;

        //      aaa
        //     f   b
        //      ggg
        //     e   c
        //      ddd
        // pins are active low, so the stored value is inverted on the way out

endpackage : disp_pkg

// ==== src/disp_wr_if.sv ====
// display write channel from the command decoder to the digit registers, one instance per display
`timescale 1ns/1ps

interface disp_wr_if
        import disp_pkg::*;
();

        logic       wr_en;              // one-cycle write strobe
        disp_kind_e wr_kind;            // hex or raw
        digit_idx_t wr_idx;             // target digit
        logic [7:0] wr_data;            // nibble or segment pattern
        logic       clr_all;            // one-cycle blank strobe

        // no back-pressure, the registers take a write every cycle
        modport decoder (
                output wr_en, wr_kind, wr_idx, wr_data, clr_all
        );

        modport regs (
                input  wr_en, wr_kind, wr_idx, wr_data, clr_all
        );

endinterface : disp_wr_if

// ==== src/spi_cmd_rx.sv ====
// SPI mode 0 slave that assembles command bytes and echoes the last one on MISO, clock_50 domain
`timescale 1ns/1ps

module spi_cmd_rx
        import cmd_pkg::*;
(
        input  logic      clock_50,     // system clock
        input  logic      arst_n,       // async reset, active low
        input  logic      spi_sclk,     // host clock, idle low
        input  logic      spi_csel,     // chip select, active low
        input  logic      spi_mosi,     // host to slave
        output logic      spi_miso,     // echo of previous byte
        output cmd_byte_t rx_byte,      // last completed byte
        output logic      rx_valid,     // pulse per byte
        output logic      frame_start   // pulse on csel fall
);

        // ====================
        // synchronizers
        // ====================
        logic [2:0] sclk_q;             // 2 sync stages + edge history
        logic [2:0] csel_q;
        logic [1:0] mosi_q;
        logic       sel;                // synced chip select, active high
        logic       sclk_rise;
        logic       sclk_fall;
        logic       csel_fall;

        always_ff @(posedge clock_50 or negedge arst_n) begin
                if (!arst_n) begin
                        sclk_q <= 3'b000;
                        csel_q <= 3'b111;               // deselected
                        mosi_q <= 2'b00;
                end else begin
                        sclk_q <= {sclk_q[1:0], spi_sclk};
                        csel_q <= {csel_q[1:0], spi_csel};
                        mosi_q <= {mosi_q[0], spi_mosi};
                end
        end

        assign sel       = ~csel_q[1];
        assign sclk_rise = sel & sclk_q[1] & ~sclk_q[2];        // sample edge
        assign sclk_fall = sel & ~sclk_q[1] & sclk_q[2];        // shift-out edge
        assign csel_fall = csel_q[2] & ~csel_q[1];

        // ====================
        // receive and echo
        // ====================
        logic [2:0] bit_cnt;            // bits taken in this byte
        cmd_byte_t  shift_q;            // incoming bits, msb first
        cmd_byte_t  next_byte;          // shift_q with the current bit
        cmd_byte_t  tx_shift;           // echo shifter, msb on miso

        assign next_byte = {shift_q[CMD_BYTE_W-2:0], mosi_q[1]};
        assign spi_miso  = tx_shift[CMD_BYTE_W-1];

        always_ff @(posedge clock_50) begin
                if (sclk_rise) begin
                        shift_q <= next_byte;
                end
        end

        always_ff @(posedge clock_50 or negedge arst_n) begin
                if (!arst_n) begin
                        bit_cnt     <= 3'd0;
                        rx_byte     <= '0;
                        tx_shift    <= '0;
                        rx_valid    <= 1'b0;
                        frame_start <= 1'b0;
                end else begin
                        rx_valid    <= 1'b0;
                        frame_start <= csel_fall;
                        if (!sel) begin
                                bit_cnt  <= 3'd0;       // partial byte dropped here
                                tx_shift <= rx_byte;    // bit 7 ready before first edge
                        end else if (sclk_rise) begin
                                bit_cnt <= bit_cnt + 3'd1;
                                if (bit_cnt == 3'd7) begin
                                        rx_byte  <= next_byte;
                                        tx_shift <= next_byte;  // echo in next byte slot
                                        rx_valid <= 1'b1;
                                end
                        end else if (sclk_fall && bit_cnt != 3'd0) begin
                                // hold bit 7 over the fall after a byte boundary
                                tx_shift <= {tx_shift[CMD_BYTE_W-2:0], 1'b0};
                        end
                end
        end

endmodule : spi_cmd_rx

// ==== src/spi_hex_display.sv ====
// top level of the SPI-driven six-digit hex display, instantiate with the board pins
`timescale 1ns/1ps

module spi_hex_display
        import cmd_pkg::*;
        import disp_pkg::*;
#(
        parameter int DEBOUNCE_CYCLES = 50000   // 1 ms at 50 MHz
) (
        input  logic clock_50,          // 50 MHz board clock
        input  logic arst_n,            // async reset, active low
        input  logic spi_sclk,          // SPI from host
        input  logic spi_csel,          // active low
        input  logic spi_mosi,
        output logic spi_miso,
        input  logic key_n,             // clear key, active low
        output seg_t hex0,              // active low digits
        output seg_t hex1,
        output seg_t hex2,
        output seg_t hex3,
        output seg_t hex4,
        output seg_t hex5
);

        // ====================
        // internal wires
        // ====================
        cmd_byte_t rx_byte;             // receiver -> decoder
        logic      rx_valid;
        logic      frame_start;
        logic      key_press;           // debouncer -> decoder

        disp_wr_if disp_wr ();          // decoder -> registers

        spi_cmd_rx spi_cmd_rx_i (
                .clock_50    (clock_50),
                .arst_n      (arst_n),
                .spi_sclk    (spi_sclk),
                .spi_csel    (spi_csel),
                .spi_mosi    (spi_mosi),
                .spi_miso    (spi_miso),
                .rx_byte     (rx_byte),
                .rx_valid    (rx_valid),
                .frame_start (frame_start)
        );

        cmd_fsm cmd_fsm_i (
                .clock_50    (clock_50),
                .arst_n      (arst_n),
                .rx_byte     (rx_byte),
                .rx_valid    (rx_valid),
                .frame_start (frame_start),
                .key_press   (key_press),
                .wr          (disp_wr.decoder)
        );

        debounce_timer #(
                .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
        ) debounce_timer_i (
                .clock_50  (clock_50),
                .arst_n    (arst_n),
                .key_n     (key_n),
                .key_press (key_press)
        );

        digit_regs digit_regs_i (
                .clock_50 (clock_50),
                .arst_n   (arst_n),
                .wr       (disp_wr.regs),
                .hex0     (hex0),
                .hex1     (hex1),
                .hex2     (hex2),
                .hex3     (hex3),
                .hex4     (hex4),
                .hex5     (hex5)
        );

endmodule : spi_hex_display

// ==== tests/tb_spi_hex_display.sv ====
// directed testbench for the SPI hex display, drives SPI frames and the clear key and checks the digits
`timescale 1ns/1ps

module tb_spi_hex_display
        import cmd_pkg::*;
        import disp_pkg::*;
();

        localparam int CLK_HALF_NS = 20;        // 40 ns period
        localparam int DRIVE_DLY   = 2;         // ns after rising edge
        localparam int HALF        = 6;         // sclk half-period in clocks
        localparam int POST_WAIT   = 8;         // settle after each frame
        localparam int NUM_FRAMES  = 19;        // frames sent by all tests
        localparam int FRAME_CYCLES = 2 * 8 * 2 * HALF + 2 * HALF + POST_WAIT;
        localparam int WATCHDOG_CYCLES = NUM_FRAMES * FRAME_CYCLES * 3;

        // standard glyphs, one 7-bit slot per nibble, gfedcba order
        localparam logic [16*7-1:0] GLYPHS = {
                7'b1110001, 7'b1111001, 7'b1011110, 7'b0111001,    // F E d C
                7'b1111100, 7'b1110111, 7'b1101111, 7'b1111111,    // b A 9 8
                7'b0000111, 7'b1111101, 7'b1101101, 7'b1100110,    // 7 6 5 4
                7'b1001111, 7'b1011011, 7'b0000110, 7'b0111111     // 3 2 1 0
        };

        logic clock_50;
        logic arst_n;
        logic spi_sclk;
        logic spi_csel;
        logic spi_mosi;
        logic spi_miso;
        logic key_n;
        seg_t hex0, hex1, hex2, hex3, hex4, hex5;

        seg_t        expected [NUM_DIGITS];     // lit segments per digit
        cmd_byte_t   last_byte;                 // last completed byte sent

        spi_hex_display #(
                .DEBOUNCE_CYCLES (16)
        ) spi_hex_display_i (
                .clock_50 (clock_50),
                .arst_n   (arst_n),
                .spi_sclk (spi_sclk),
                .spi_csel (spi_csel),
                .spi_mosi (spi_mosi),
                .spi_miso (spi_miso),
                .key_n    (key_n),
                .hex0     (hex0),
                .hex1     (hex1),
                .hex2     (hex2),
                .hex3     (hex3),
                .hex4     (hex4),
                .hex5     (hex5)
        );

        always #(CLK_HALF_NS) clock_50 = ~clock_50;

        // ====================
        // helpers
        // ====================
        function automatic seg_t glyph_of(input logic [3:0] nib);
                return GLYPHS[nib*7 +: 7];
        endfunction

        function automatic cmd_byte_t make_cmd(input cmd_op_e op, input digit_idx_t idx);
                return {op, 2'b00, idx};        // op | xx | idx
        endfunction

        function automatic seg_t read_digit(input int i);
                case (i)
                        0:       return hex0;
                        1:       return hex1;
                        2:       return hex2;
                        3:       return hex3;
                        4:       return hex4;
                        default: return hex5;
                endcase
        endfunction

        task automatic wait_cycles(input int n);
                repeat (n) begin
                        @(posedge clock_50);
                        #(DRIVE_DLY);           // inputs change off the edge
                end
        endtask

        task automatic check_seg(input string name, input seg_t got, input seg_t exp);
                if (got !== exp) begin
                        $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
                        $display("Finished with errors");
                        $fatal(1, "display mismatch");
                end
        endtask

        task automatic check_byte(input string name, input cmd_byte_t got, input cmd_byte_t exp);
                if (got !== exp) begin
                        $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
                        $display("Finished with errors");
                        $fatal(1, "echo mismatch");
                end
        endtask

        task automatic check_display();
                for (int i = 0; i < NUM_DIGITS; i++) begin
                        check_seg($sformatf("hex%0d", i), read_digit(i), ~expected[i]);
                end
        endtask

        // ====================
        // SPI host
        // ====================
        // mode 0, msb first, miso sampled just before each rising sclk
        task automatic spi_byte(input cmd_byte_t tx, input int nbits, output cmd_byte_t rx);
                rx = '0;
                for (int i = 7; i > 7 - nbits; i--) begin
                        spi_mosi = tx[i];
                        wait_cycles(HALF);
                        rx[i] = spi_miso;
                        spi_sclk = 1'b1;
                        wait_cycles(HALF);
                        spi_sclk = 1'b0;
                end
        endtask

        task automatic send_frame(input cmd_byte_t b0, input cmd_byte_t b1, input int nbytes);
                cmd_byte_t echo;
                spi_csel = 1'b0;
                wait_cycles(HALF);
                spi_byte(b0, 8, echo);
                check_byte("spi_miso", echo, last_byte);        // previous byte echoed
                last_byte = b0;
                if (nbytes > 1) begin
                        spi_byte(b1, 8, echo);
                        check_byte("spi_miso", echo, last_byte);
                        last_byte = b1;
                end
                wait_cycles(HALF);
                spi_csel = 1'b1;
                wait_cycles(POST_WAIT);
        endtask

        task automatic send_partial(input cmd_byte_t b, input int nbits);
                cmd_byte_t echo;
                spi_csel = 1'b0;
                wait_cycles(HALF);
                spi_byte(b, nbits, echo);               // byte cut short
                wait_cycles(HALF);
                spi_csel = 1'b1;
                wait_cycles(POST_WAIT);
        endtask

        // ====================
        // directed tests
        // ====================
        task automatic test_reset_blank();
                check_display();                        // all ones on every digit
        endtask

        task automatic test_write_hex();
                cmd_byte_t data;
                for (int d = 0; d < NUM_DIGITS; d++) begin
                        data = cmd_byte_t'($urandom);
                        expected[d] = glyph_of(data[3:0]);      // upper nibble ignored
                        send_frame(make_cmd(op_write_hex, digit_idx_t'(d)), data, 2);
                        check_display();
                end
        endtask

        task automatic test_write_raw();
                cmd_byte_t data;
                int        d;
                d = $urandom % NUM_DIGITS;
                data = cmd_byte_t'($urandom);
                expected[d] = data[6:0];
                send_frame(make_cmd(op_write_raw, digit_idx_t'(d)), data, 2);
                check_display();
                data = cmd_byte_t'($urandom);
                send_frame(make_cmd(op_write_raw, 3'd6), data, 2);     // no such digit
                check_display();
        endtask

        task automatic test_clear();
                send_frame(make_cmd(op_clear, 3'd0), 8'h00, 1);
                for (int i = 0; i < NUM_DIGITS; i++) begin
                        expected[i] = SEG_BLANK;
                end
                check_display();
                expected[1] = glyph_of(4'h7);
                send_frame(make_cmd(op_write_hex, 3'd1), 8'h07, 2);
                expected[4] = glyph_of(4'hC);
                send_frame(make_cmd(op_write_hex, 3'd4), 8'h0C, 2);
                check_display();
                send_partial(make_cmd(op_write_hex, 3'd2), 4);  // cut after 4 bits
                check_display();
                send_frame(make_cmd(op_clear, 3'd0), 8'h00, 1);
                expected[1] = SEG_BLANK;
                expected[4] = SEG_BLANK;
                check_display();
        endtask

        task automatic test_echo();
                cmd_byte_t b0;
                cmd_byte_t b1;
                for (int n = 0; n < 3; n++) begin
                        b0 = {1'b1, 7'($urandom)};      // reserved op, decodes as nop
                        send_frame(b0, 8'h00, 1);
                end
                b0 = {1'b1, 7'($urandom)};
                b1 = {1'b1, 7'($urandom)};
                send_frame(b0, b1, 2);                  // echo within one frame
                check_display();
        endtask

        task automatic test_key_clear();
                expected[0] = glyph_of(4'hA);
                send_frame(make_cmd(op_write_hex, 3'd0), 8'h0A, 2);
                expected[3] = glyph_of(4'h5);
                send_frame(make_cmd(op_write_hex, 3'd3), 8'h05, 2);
                check_display();
                key_n = 1'b0;                           // short glitch
                wait_cycles(5);
                key_n = 1'b1;
                wait_cycles(40);
                check_display();
                key_n = 1'b0;                           // real press
                wait_cycles(40);
                key_n = 1'b1;
                wait_cycles(30);
                for (int i = 0; i < NUM_DIGITS; i++) begin
                        expected[i] = SEG_BLANK;
                end
                check_display();
        endtask

        // ====================
        // main sequence and watchdog
        // ====================
        initial begin
                void'($urandom(44123));
                clock_50  = 1'b0;
                arst_n    = 1'b0;
                spi_sclk  = 1'b0;
                spi_csel  = 1'b1;
                spi_mosi  = 1'b0;
                key_n     = 1'b1;
                last_byte = '0;                 // echo byte after reset
                for (int i = 0; i < NUM_DIGITS; i++) begin
                        expected[i] = SEG_BLANK;
                end
                wait_cycles(8);
                arst_n = 1'b1;
                wait_cycles(2);
                test_reset_blank();
                test_write_hex();
                test_write_raw();
                test_clear();
                test_echo();
                test_key_clear();
                $display("Finished with no errors");
                $finish;
        end

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clock_50);
                $display("Timeout: the tests did not complete within %0d clock cycles",
                         WATCHDOG_CYCLES);
                $display("Finished with errors");
                $fatal(1, "watchdog expired");
        end

endmodule : tb_spi_hex_display
